// ==== Makefile ====
# Verilator build and run of the cluster peripheral testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
		--top-module tb_cluster_periph -o tb_cluster_periph
	./obj_dir/tb_cluster_periph

clean:
	rm -rf obj_dir

// ==== hw/cluster_ctrl_regs.sv ====
// cluster control registers: end of computation, per-core fetch enable, boot address

module cluster_ctrl_regs #(
  parameter int                NB_CORES  = 4,
  parameter periph_pkg::addr_t BOOT_ADDR = 32'h1C00_0000
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  periph_pkg::reg_idx_t reg_idx_i,
  input  logic                 wen_i,
  input  periph_pkg::data_t    wdata_i,
  output periph_pkg::data_t    rdata_o,
  output logic                 eoc_o,
  output logic [NB_CORES-1:0]  fetch_enable_o,
  output periph_pkg::addr_t    boot_addr_o
);

  logic                eoc_q;
  logic [NB_CORES-1:0] fetch_en_q;
  periph_pkg::addr_t   boot_addr_q;
  periph_pkg::data_t   rdata_d;
  periph_pkg::data_t   rdata_q;
  logic                wr;

  // wen high is a read
  assign wr = req_i && !wen_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      eoc_q       <= 1'b0;
      fetch_en_q  <= '0;
      boot_addr_q <= BOOT_ADDR;
    end else if (wr) begin
      case (reg_idx_i)
        periph_pkg::CTRL_EOC:       eoc_q       <= wdata_i[0];
        periph_pkg::CTRL_FETCH_EN:  fetch_en_q  <= wdata_i[NB_CORES-1:0];
        periph_pkg::CTRL_BOOT_ADDR: boot_addr_q <= wdata_i;
        default: ;
      endcase
    end
  end

  // read mux
  always_comb begin
    case (reg_idx_i)
      periph_pkg::CTRL_EOC:       rdata_d = periph_pkg::data_t'(eoc_q);
      periph_pkg::CTRL_FETCH_EN:  rdata_d = periph_pkg::data_t'(fetch_en_q);
      periph_pkg::CTRL_BOOT_ADDR: rdata_d = boot_addr_q;
      default:                    rdata_d = periph_pkg::READ_ZERO;
    endcase
  end

  // sampled on the strobe, returned in the response cycle
  always_ff @(posedge clk_i) begin
    if (req_i && wen_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o        = rdata_q;
  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

// ==== hw/cluster_periph_top.sv ====
// peripheral subsystem top: bus front end wired to control regs, timer and event unit

module cluster_periph_top #(
  parameter int                NB_CORES  = 4,
  parameter int                ID_WIDTH  = 5,
  parameter periph_pkg::addr_t BOOT_ADDR = 32'h1C00_0000
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // configuration bus
  input  logic                req_i,
  input  periph_pkg::addr_t   addr_i,
  input  logic                wen_i,
  input  periph_pkg::data_t   wdata_i,
  input  logic [ID_WIDTH-1:0] id_i,
  output logic                gnt_o,
  output logic                r_valid_o,
  output logic [ID_WIDTH-1:0] r_id_o,
  output periph_pkg::data_t   r_rdata_o,
  // events in
  input  logic [3:0]          ext_evt_i,
  input  logic                dma_evt_i,
  // cluster control out
  output logic                eoc_o,
  output logic [NB_CORES-1:0] fetch_enable_o,
  output periph_pkg::addr_t   boot_addr_o,
  output logic [NB_CORES-1:0] irq_req_o,
  output logic                timer_busy_o
);

  logic                 ctrl_req;
  logic                 timer_req;
  logic                 event_req;
  periph_pkg::reg_idx_t reg_idx;
  logic                 wen;
  periph_pkg::data_t    wdata;
  periph_pkg::data_t    ctrl_rdata;
  periph_pkg::data_t    timer_rdata;
  periph_pkg::data_t    event_rdata;
  logic                 timer_irq;

  //****************************************
  // bus front end
  //****************************************
  periph_bus_ctrl #(
    .ID_WIDTH ( ID_WIDTH )
  ) i_bus_ctrl (
    .clk_i, .rst_ni, .req_i, .addr_i, .wen_i, .wdata_i, .id_i,
    .gnt_o, .r_valid_o, .r_id_o, .r_rdata_o,
    .ctrl_req_o    ( ctrl_req    ),
    .timer_req_o   ( timer_req   ),
    .event_req_o   ( event_req   ),
    .reg_idx_o     ( reg_idx     ),
    .wen_o         ( wen         ),
    .wdata_o       ( wdata       ),
    .ctrl_rdata_i  ( ctrl_rdata  ),
    .timer_rdata_i ( timer_rdata ),
    .event_rdata_i ( event_rdata )
  );

  //****************************************
  // slaves
  //****************************************
  cluster_ctrl_regs #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) i_ctrl_regs (
    .clk_i, .rst_ni,
    .req_i          ( ctrl_req       ),
    .reg_idx_i      ( reg_idx        ),
    .wen_i          ( wen            ),
    .wdata_i        ( wdata          ),
    .rdata_o        ( ctrl_rdata     ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  cluster_timer i_timer (
    .clk_i, .rst_ni,
    .req_i        ( timer_req    ),
    .reg_idx_i    ( reg_idx      ),
    .wen_i        ( wen          ),
    .wdata_i      ( wdata        ),
    .rdata_o      ( timer_rdata  ),
    .timer_irq_o  ( timer_irq    ),
    .timer_busy_o ( timer_busy_o )
  );

  event_unit #(
    .NB_CORES ( NB_CORES )
  ) i_event_unit (
    .clk_i, .rst_ni,
    .req_i       ( event_req   ),
    .reg_idx_i   ( reg_idx     ),
    .wen_i       ( wen         ),
    .wdata_i     ( wdata       ),
    .ext_evt_i   ( ext_evt_i   ),
    .timer_evt_i ( timer_irq   ),
    .dma_evt_i   ( dma_evt_i   ),
    .rdata_o     ( event_rdata ),
    .irq_req_o   ( irq_req_o   )
  );

endmodule

// ==== hw/cluster_timer.sv ====
// cluster timer: free-running 32-bit counter with compare match and interrupt pulse

module cluster_timer (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  periph_pkg::reg_idx_t reg_idx_i,
  input  logic                 wen_i,
  input  periph_pkg::data_t    wdata_i,
  output periph_pkg::data_t    rdata_o,
  output logic                 timer_irq_o,
  output logic                 timer_busy_o
);

  logic              enable_q;
  logic [31:0]       count_q;
  logic [31:0]       cmp_q;
  logic              match;
  logic              wr;
  periph_pkg::data_t rdata_d;
  periph_pkg::data_t rdata_q;

  assign wr    = req_i && !wen_i;
  assign match = enable_q && (count_q == cmp_q);

  //****************************************
  // configuration
  //****************************************
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= 1'b0;
      cmp_q    <= '0;
    end else if (wr) begin
      if (reg_idx_i == periph_pkg::TIMER_CFG) begin
        enable_q <= wdata_i[0];
      end
      if (reg_idx_i == periph_pkg::TIMER_CMP) begin
        cmp_q <= wdata_i;
      end
    end
  end

  //****************************************
  // counter
  //****************************************
  // a load from the bus beats counting and the restart
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (wr && (reg_idx_i == periph_pkg::TIMER_COUNT)) begin
      count_q <= wdata_i;
    end else if (match) begin
      count_q <= '0;
    end else if (enable_q) begin
      count_q <= count_q + 32'd1;
    end
  end

  always_comb begin
    case (reg_idx_i)
      periph_pkg::TIMER_CFG:   rdata_d = periph_pkg::data_t'(enable_q);
      periph_pkg::TIMER_COUNT: rdata_d = count_q;
      periph_pkg::TIMER_CMP:   rdata_d = cmp_q;
      default:                 rdata_d = periph_pkg::READ_ZERO;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i && wen_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o      = rdata_q;
  assign timer_irq_o  = match;  // one cycle, count restarts right after
  assign timer_busy_o = enable_q;

endmodule

// ==== hw/event_unit.sv ====
// event unit: sticky event buffer with write-1-to-clear and per-core masked interrupt requests

module event_unit #(
  parameter int NB_CORES = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  periph_pkg::reg_idx_t reg_idx_i,
  input  logic                 wen_i,
  input  periph_pkg::data_t    wdata_i,
  input  logic [3:0]           ext_evt_i,
  input  logic                 timer_evt_i,
  input  logic                 dma_evt_i,
  output periph_pkg::data_t    rdata_o,
  output logic [NB_CORES-1:0]  irq_req_o
);

  periph_pkg::evt_t  evt;
  periph_pkg::evt_t  evt_clr;
  periph_pkg::evt_t  evt_buf_q;
  periph_pkg::evt_t  mask_q [NB_CORES];
  logic              wr;
  periph_pkg::data_t rdata_d;
  periph_pkg::data_t rdata_q;

  assign wr = req_i && !wen_i;

  // event lines at their fixed positions, spare lines stay low
  always_comb begin
    evt = '0;
    evt[periph_pkg::EVT_EXT_LSB +: 4] = ext_evt_i;
    evt[periph_pkg::EVT_TIMER]        = timer_evt_i;
    evt[periph_pkg::EVT_DMA]          = dma_evt_i;
  end

  //****************************************
  // sticky buffer
  //****************************************
  assign evt_clr = (wr && (reg_idx_i == periph_pkg::EVT_BUFFER)) ?
                   wdata_i[periph_pkg::NB_EVT-1:0] : '0;

  // new events win over a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_buf_q <= '0;
    end else begin
      evt_buf_q <= (evt_buf_q & ~evt_clr) | evt;
    end
  end

  //****************************************
  // per-core masks
  //****************************************
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int c = 0; c < NB_CORES; c++) begin
        mask_q[c] <= '0;
      end
    end else if (wr) begin
      for (int c = 0; c < NB_CORES; c++) begin
        if (reg_idx_i == periph_pkg::reg_idx_t'(periph_pkg::EVT_MASK_BASE + c)) begin
          mask_q[c] <= wdata_i[periph_pkg::NB_EVT-1:0];
        end
      end
    end
  end

  for (genvar c = 0; c < NB_CORES; c++) begin : gen_irq
    assign irq_req_o[c] = |(evt_buf_q & mask_q[c]);
  end

  always_comb begin
    rdata_d = periph_pkg::READ_ZERO;
    if (reg_idx_i == periph_pkg::EVT_BUFFER) begin
      rdata_d = periph_pkg::data_t'(evt_buf_q);
    end
    for (int c = 0; c < NB_CORES; c++) begin
      if (reg_idx_i == periph_pkg::reg_idx_t'(periph_pkg::EVT_MASK_BASE + c)) begin
        rdata_d = periph_pkg::data_t'(mask_q[c]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && wen_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== hw/periph_bus_ctrl.sv ====
// bus front end: decodes the slot, strobes one slave and builds the one-cycle response

module periph_bus_ctrl #(
  parameter int ID_WIDTH = 5
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // external request
  input  logic                    req_i,
  input  periph_pkg::addr_t       addr_i,
  input  logic                    wen_i,
  input  periph_pkg::data_t       wdata_i,
  input  logic [ID_WIDTH-1:0]     id_i,
  output logic                    gnt_o,
  // external response
  output logic                    r_valid_o,
  output logic [ID_WIDTH-1:0]     r_id_o,
  output periph_pkg::data_t       r_rdata_o,
  // slave side
  output logic                    ctrl_req_o,
  output logic                    timer_req_o,
  output logic                    event_req_o,
  output periph_pkg::reg_idx_t    reg_idx_o,
  output logic                    wen_o,
  output periph_pkg::data_t       wdata_o,
  input  periph_pkg::data_t       ctrl_rdata_i,
  input  periph_pkg::data_t       timer_rdata_i,
  input  periph_pkg::data_t       event_rdata_i
);

  periph_pkg::slot_e   slot;
  periph_pkg::slot_e   slot_q;
  logic                valid_q;
  logic                read_q;
  logic [ID_WIDTH-1:0] id_q;

  // no back-pressure, every request is taken
  assign gnt_o = req_i;

  assign slot      = periph_pkg::slot_e'(addr_i[periph_pkg::SLOT_LSB +: 2]);
  assign reg_idx_o = addr_i[periph_pkg::REG_IDX_LSB +: 4];
  assign wen_o     = wen_i;
  assign wdata_o   = wdata_i;

  //****************************************
  // slot decode
  //****************************************
  always_comb begin
    ctrl_req_o  = 1'b0;
    timer_req_o = 1'b0;
    event_req_o = 1'b0;
    if (req_i) begin
      case (slot)
        periph_pkg::SLOT_CTRL:  ctrl_req_o  = 1'b1;
        periph_pkg::SLOT_TIMER: timer_req_o = 1'b1;
        periph_pkg::SLOT_EVENT: event_req_o = 1'b1;
        default: ;  // error slot has no slave behind it
      endcase
    end
  end

  //****************************************
  // response path
  //****************************************
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      read_q  <= 1'b0;
      slot_q  <= periph_pkg::SLOT_CTRL;
    end else begin
      valid_q <= req_i;
      if (req_i) begin
        read_q <= wen_i;
        slot_q <= slot;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      id_q <= id_i;
    end
  end

  always_comb begin
    case (slot_q)
      periph_pkg::SLOT_CTRL:  r_rdata_o = read_q ? ctrl_rdata_i  : '0;
      periph_pkg::SLOT_TIMER: r_rdata_o = read_q ? timer_rdata_i : '0;
      periph_pkg::SLOT_EVENT: r_rdata_o = read_q ? event_rdata_i : '0;
      // error slot flags reads and writes alike
      default:                r_rdata_o = periph_pkg::ERROR_RDATA;
    endcase
  end

  assign r_valid_o = valid_q;
  assign r_id_o    = id_q;

endmodule

// ==== hw/periph_pkg.sv ====
// shared bus types, slot map, register indices and event lines for the cluster peripherals

package periph_pkg;

  // bus payload
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // slot select sits in address bits 11:10, register word index in bits 5:2
  localparam int SLOT_LSB    = 10;
  localparam int REG_IDX_LSB = 2;

  typedef enum logic [1:0] {
    SLOT_CTRL  = 2'd0,
    SLOT_TIMER = 2'd1,
    SLOT_EVENT = 2'd2,
    SLOT_ERROR = 2'd3
  } slot_e;

  typedef logic [3:0] reg_idx_t;

  // control register block
  localparam reg_idx_t CTRL_EOC       = 4'd0;
  localparam reg_idx_t CTRL_FETCH_EN  = 4'd1;
  localparam reg_idx_t CTRL_BOOT_ADDR = 4'd2;

  // timer, bit 0 of cfg is the enable
  localparam reg_idx_t TIMER_CFG   = 4'd0;
  localparam reg_idx_t TIMER_COUNT = 4'd1;
  localparam reg_idx_t TIMER_CMP   = 4'd2;

  // event unit, mask of core i at EVT_MASK_BASE + i
  localparam reg_idx_t EVT_BUFFER    = 4'd0;
  localparam reg_idx_t EVT_MASK_BASE = 4'd1;

  localparam int NB_EVT = 8;
  typedef logic [NB_EVT-1:0] evt_t;

  // event line map, lines 6 and 7 are spare
  localparam int EVT_EXT_LSB = 0;
  localparam int EVT_TIMER   = 4;
  localparam int EVT_DMA     = 5;

  localparam data_t ERROR_RDATA = 32'hBADC_AB7E;
  localparam data_t READ_ZERO   = 32'h0000_0000;

endpackage

// ==== sim/tb_tasks.svh ====
// bus access, compare and directed test tasks that the testbench top includes
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

  localparam int                RESP_TIMEOUT = 8;
  localparam int                POLL_LIMIT   = 100;
  localparam periph_pkg::addr_t PERIPH_BASE  = 32'h1020_0000;

  //****************************************
  // failure and compare tasks
  //****************************************
  task automatic abort_run(input string line);
    $display("%s", line);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input periph_pkg::data_t got, input periph_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_id(input logic [ID_WIDTH-1:0] got, input logic [ID_WIDTH-1:0] exp,
                          input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_bits(input logic [NB_CORES-1:0] got, input logic [NB_CORES-1:0] exp,
                            input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  //****************************************
  // bus access
  //****************************************
  task automatic step_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // slot in address bits 11:10, word index in bits 5:2
  function automatic periph_pkg::addr_t slot_addr(input periph_pkg::slot_e slot,
                                                  input periph_pkg::reg_idx_t idx);
    periph_pkg::addr_t a;
    a = PERIPH_BASE;
    a[11:10] = slot;
    a[5:2] = idx;
    return a;
  endfunction

  task automatic bus_access(input periph_pkg::slot_e slot, input periph_pkg::reg_idx_t idx,
                            input logic is_read, input periph_pkg::data_t data,
                            output periph_pkg::data_t rdata);
    logic [31:0]         r;
    logic [ID_WIDTH-1:0] id;
    int                  waited;
    r = next_rand();
    id = r[ID_WIDTH-1:0];
    req_i   = 1'b1;
    addr_i  = slot_addr(slot, idx);
    wen_i   = is_read;
    wdata_i = data;
    id_i    = id;
    #1;
    check_flag(gnt_o, 1'b1, "grant");
    step_cycle();
    req_i = 1'b0;
    waited = 0;
    while (!r_valid_o) begin
      if (waited == RESP_TIMEOUT) begin
        abort_run("timed out waiting for a bus response");
      end
      step_cycle();
      waited++;
    end
    check_id(r_id_o, id, "response id");
    rdata = r_rdata_o;
  endtask

  task automatic bus_write(input periph_pkg::slot_e slot, input periph_pkg::reg_idx_t idx,
                           input periph_pkg::data_t data);
    periph_pkg::data_t rd;
    bus_access(slot, idx, 1'b0, data, rd);
    check_data(rd, 32'h0, "write response data");
  endtask

  task automatic bus_read(input periph_pkg::slot_e slot, input periph_pkg::reg_idx_t idx,
                          output periph_pkg::data_t rdata);
    bus_access(slot, idx, 1'b1, 32'h0, rdata);
  endtask

  task automatic expect_read(input periph_pkg::slot_e slot, input periph_pkg::reg_idx_t idx,
                             input periph_pkg::data_t exp, input string what);
    periph_pkg::data_t rd;
    bus_read(slot, idx, rd);
    check_data(rd, exp, what);
  endtask

  //****************************************
  // directed tests
  //****************************************
  task automatic reset_and_ctrl_regs();
    periph_pkg::data_t v;
    check_flag(r_valid_o, 1'b0, "r_valid_o after reset");
    check_flag(eoc_o, 1'b0, "eoc_o after reset");
    check_bits(fetch_enable_o, '0, "fetch_enable_o after reset");
    check_bits(irq_req_o, '0, "irq_req_o after reset");
    check_flag(timer_busy_o, 1'b0, "timer_busy_o after reset");
    check_data(boot_addr_o, BOOT_ADDR, "boot_addr_o after reset");
    expect_read(periph_pkg::SLOT_CTRL, periph_pkg::CTRL_EOC, 32'h0, "eoc reg");
    expect_read(periph_pkg::SLOT_CTRL, periph_pkg::CTRL_FETCH_EN, 32'h0, "fetch en reg");
    expect_read(periph_pkg::SLOT_CTRL, periph_pkg::CTRL_BOOT_ADDR, BOOT_ADDR, "boot reg");
    expect_read(periph_pkg::SLOT_TIMER, periph_pkg::TIMER_COUNT, 32'h0, "timer count");
    expect_read(periph_pkg::SLOT_TIMER, periph_pkg::TIMER_CMP, 32'h0, "timer compare");
    expect_read(periph_pkg::SLOT_EVENT, periph_pkg::EVT_BUFFER, 32'h0, "event buffer");
    for (int c = 0; c < NB_CORES; c++) begin
      expect_read(periph_pkg::SLOT_EVENT,
                  periph_pkg::reg_idx_t'(periph_pkg::EVT_MASK_BASE + c), 32'h0, "core mask");
    end

    // only the low NB_CORES bits of fetch enable are kept
    v = next_rand();
    bus_write(periph_pkg::SLOT_CTRL, periph_pkg::CTRL_FETCH_EN, v);
    check_bits(fetch_enable_o, v[NB_CORES-1:0], "fetch_enable_o");
    expect_read(periph_pkg::SLOT_CTRL, periph_pkg::CTRL_FETCH_EN,
                periph_pkg::data_t'(v[NB_CORES-1:0]), "fetch en read-back");

    v = next_rand();
    bus_write(periph_pkg::SLOT_CTRL, periph_pkg::CTRL_BOOT_ADDR, v);
    check_data(boot_addr_o, v, "boot_addr_o");
    expect_read(periph_pkg::SLOT_CTRL, periph_pkg::CTRL_BOOT_ADDR, v, "boot read-back");

    bus_write(periph_pkg::SLOT_CTRL, periph_pkg::CTRL_EOC, 32'h1);
    check_flag(eoc_o, 1'b1, "eoc_o");
    expect_read(periph_pkg::SLOT_CTRL, periph_pkg::CTRL_EOC, 32'h1, "eoc read-back");
  endtask

  task automatic timer_compare_irq();
    periph_pkg::data_t rd;
    int                polls;
    logic              seen;
    bus_write(periph_pkg::SLOT_TIMER, periph_pkg::TIMER_CMP, 32'd20);
    bus_write(periph_pkg::SLOT_TIMER, periph_pkg::TIMER_COUNT, 32'd0);
    bus_write(periph_pkg::SLOT_TIMER, periph_pkg::TIMER_CFG, 32'h1);
    check_flag(timer_busy_o, 1'b1, "timer_busy_o");
    polls = 0;
    seen = 1'b0;
    while (!seen) begin
      if (polls == POLL_LIMIT) begin
        abort_run("the timer event never reached the event buffer");
      end
      bus_read(periph_pkg::SLOT_EVENT, periph_pkg::EVT_BUFFER, rd);
      seen = rd[periph_pkg::EVT_TIMER];
      polls++;
    end
    bus_read(periph_pkg::SLOT_TIMER, periph_pkg::TIMER_COUNT, rd);
    if (rd > 32'd20) begin
      abort_run($sformatf("error at %0t ns: timer count %0d is above the compare value 20",
                          $time, rd));
    end
    check_flag(timer_busy_o, 1'b1, "timer_busy_o while counting");
    // stop the timer so that it leaves the event buffer alone
    bus_write(periph_pkg::SLOT_TIMER, periph_pkg::TIMER_CFG, 32'h0);
    check_flag(timer_busy_o, 1'b0, "timer_busy_o after disable");
    bus_write(periph_pkg::SLOT_EVENT, periph_pkg::EVT_BUFFER, 32'hFF);
    expect_read(periph_pkg::SLOT_EVENT, periph_pkg::EVT_BUFFER, 32'h0, "buffer after clear");
  endtask

  task automatic event_mask_irqs();
    periph_pkg::evt_t    exp_buf;
    periph_pkg::data_t   mask [NB_CORES];
    logic [NB_CORES-1:0] exp_irq;
    int                  line;
    for (int l = 0; l < 5; l++) begin
      exp_buf = '0;
      // lines 0 to 3 are external and the fifth pass raises the DMA line
      if (l < 4) begin
        ext_evt_i[l] = 1'b1;
        line = periph_pkg::EVT_EXT_LSB + l;
      end else begin
        dma_evt_i = 1'b1;
        line = periph_pkg::EVT_DMA;
      end
      exp_buf[line] = 1'b1;
      step_cycle();
      ext_evt_i = '0;
      dma_evt_i = 1'b0;
      for (int c = 0; c < NB_CORES; c++) begin
        mask[c] = next_rand();
        bus_write(periph_pkg::SLOT_EVENT,
                  periph_pkg::reg_idx_t'(periph_pkg::EVT_MASK_BASE + c), mask[c]);
        // one pending line reaches core c only through its own mask bit
        exp_irq[c] = mask[c][line];
      end
      check_bits(irq_req_o, exp_irq, "irq_req_o");
      expect_read(periph_pkg::SLOT_EVENT, periph_pkg::EVT_BUFFER,
                  periph_pkg::data_t'(exp_buf), "event buffer");
      bus_write(periph_pkg::SLOT_EVENT, periph_pkg::EVT_BUFFER, periph_pkg::data_t'(exp_buf));
      check_bits(irq_req_o, '0, "irq_req_o after clear");
      expect_read(periph_pkg::SLOT_EVENT, periph_pkg::EVT_BUFFER, 32'h0, "buffer after clear");
    end
  endtask

  task automatic error_slot_and_ids();
    periph_pkg::slot_e    slots [4];
    periph_pkg::reg_idx_t idxs  [4];
    periph_pkg::data_t    exp   [4];
    logic [ID_WIDTH-1:0]  ids   [4];
    periph_pkg::data_t    boot;
    periph_pkg::data_t    cmp;
    periph_pkg::data_t    mask;
    logic [31:0]          r;
    boot = next_rand();
    cmp = next_rand();
    mask = next_rand();
    bus_write(periph_pkg::SLOT_CTRL, periph_pkg::CTRL_BOOT_ADDR, boot);
    bus_write(periph_pkg::SLOT_TIMER, periph_pkg::TIMER_CMP, cmp);
    bus_write(periph_pkg::SLOT_EVENT, periph_pkg::EVT_MASK_BASE, mask);
    slots[0] = periph_pkg::SLOT_CTRL;
    idxs[0]  = periph_pkg::CTRL_BOOT_ADDR;
    exp[0]   = boot;
    slots[1] = periph_pkg::SLOT_TIMER;
    idxs[1]  = periph_pkg::TIMER_CMP;
    exp[1]   = cmp;
    slots[2] = periph_pkg::SLOT_EVENT;
    idxs[2]  = periph_pkg::EVT_MASK_BASE;
    exp[2]   = periph_pkg::data_t'(mask[periph_pkg::NB_EVT-1:0]);
    r = next_rand();
    slots[3] = periph_pkg::SLOT_ERROR;
    idxs[3]  = r[3:0];
    exp[3]   = periph_pkg::ERROR_RDATA;
    for (int i = 0; i < 4; i++) begin
      r = next_rand();
      ids[i] = r[ID_WIDTH-1:0];
    end
    // a new request every cycle with each response on the next edge
    for (int i = 0; i < 4; i++) begin
      req_i   = 1'b1;
      addr_i  = slot_addr(slots[i], idxs[i]);
      wen_i   = 1'b1;
      wdata_i = '0;
      id_i    = ids[i];
      step_cycle();
      check_flag(r_valid_o, 1'b1, "back-to-back response valid");
      check_id(r_id_o, ids[i], "back-to-back response id");
      check_data(r_rdata_o, exp[i], "back-to-back read data");
    end
    req_i = 1'b0;
    step_cycle();
    check_flag(r_valid_o, 1'b0, "r_valid_o after the last response");
  endtask

  task automatic unmapped_offset_reads();
    for (int i = 3; i < 16; i++) begin
      expect_read(periph_pkg::SLOT_CTRL, periph_pkg::reg_idx_t'(i),
                  periph_pkg::READ_ZERO, "unmapped ctrl offset");
      expect_read(periph_pkg::SLOT_TIMER, periph_pkg::reg_idx_t'(i),
                  periph_pkg::READ_ZERO, "unmapped timer offset");
    end
    for (int i = periph_pkg::EVT_MASK_BASE + NB_CORES; i < 16; i++) begin
      expect_read(periph_pkg::SLOT_EVENT, periph_pkg::reg_idx_t'(i),
                  periph_pkg::READ_ZERO, "unmapped event offset");
    end
  endtask

`endif

// ==== sim/tb_cluster_periph.sv ====
// testbench top for the cluster peripherals: clock, reset, DUT and the directed test sequence

module tb_cluster_periph;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int                NB_CORES  = 4;
  localparam int                ID_WIDTH  = 5;
  localparam periph_pkg::addr_t BOOT_ADDR = 32'h1C00_0000;

  logic                clk_i;
  logic                rst_ni;
  logic                req_i;
  periph_pkg::addr_t   addr_i;
  logic                wen_i;
  periph_pkg::data_t   wdata_i;
  logic [ID_WIDTH-1:0] id_i;
  logic                gnt_o;
  logic                r_valid_o;
  logic [ID_WIDTH-1:0] r_id_o;
  periph_pkg::data_t   r_rdata_o;
  logic [3:0]          ext_evt_i;
  logic                dma_evt_i;
  logic                eoc_o;
  logic [NB_CORES-1:0] fetch_enable_o;
  periph_pkg::addr_t   boot_addr_o;
  logic [NB_CORES-1:0] irq_req_o;
  logic                timer_busy_o;

  logic [31:0] rng_state = 32'he3fb_b577;

  cluster_periph_top #(
    .NB_CORES  ( NB_CORES  ),
    .ID_WIDTH  ( ID_WIDTH  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) DUT (
    .clk_i, .rst_ni,
    .req_i, .addr_i, .wen_i, .wdata_i, .id_i,
    .gnt_o, .r_valid_o, .r_id_o, .r_rdata_o,
    .ext_evt_i, .dma_evt_i,
    .eoc_o, .fetch_enable_o, .boot_addr_o, .irq_req_o, .timer_busy_o
  );

  // xorshift32 generator for ids and random data
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  `include "tb_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //****************************************
  // test sequence
  //****************************************
  initial begin
    rst_ni    = 1'b0;
    req_i     = 1'b0;
    addr_i    = '0;
    wen_i     = 1'b0;
    wdata_i   = '0;
    id_i      = '0;
    ext_evt_i = '0;
    dma_evt_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    reset_and_ctrl_regs();
    timer_compare_irq();
    event_mask_irqs();
    error_slot_and_ids();
    unmapped_offset_reads();

    $display("** PASS **");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+sim
hw/periph_pkg.sv
hw/periph_bus_ctrl.sv
hw/cluster_ctrl_regs.sv
hw/cluster_timer.sv
hw/event_unit.sv
hw/cluster_periph_top.sv
sim/tb_cluster_periph.sv
